//--- design/soc_pkg.sv
// bus types, address map, slave indices, register offsets, byte-enable helpers
package soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;
    typedef logic [7:0]  irq_id_t;
    typedef logic [7:0]  reg_off_t;   // byte offset inside a slave

    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        word_t wdata;
    } obi_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        logic  err;
        word_t rdata;
    } obi_rsp_t;

    // address map
    localparam int N_SLAVES   = 4;
    localparam int SLV_TIMER0 = 0;
    localparam int SLV_TIMER1 = 1;
    localparam int SLV_GPIO   = 2;
    localparam int SLV_RVIC   = 3;

    typedef logic [$clog2(N_SLAVES)-1:0] slv_idx_t;

    localparam addr_t SLAVE_BASE [N_SLAVES] = '{
        32'h1000_0000,
        32'h1000_1000,
        32'h2000_0000,
        32'h3000_0000
    };
    localparam addr_t SLAVE_MASK [N_SLAVES] = '{default: 32'hFFFF_F000};

    // interrupt sources, index is the id seen at the controller
    localparam int N_IRQ_SRC  = 3;
    localparam int IRQ_TIMER0 = 0;
    localparam int IRQ_TIMER1 = 1;
    localparam int IRQ_GPIO   = 2;

    localparam reg_off_t TMR_CTRL  = 8'h00;
    localparam reg_off_t TMR_VALUE = 8'h04;
    localparam reg_off_t TMR_COUNT = 8'h08;

    localparam int TMR_CTRL_EN     = 0;
    localparam int TMR_CTRL_IRQ_EN = 1;
    localparam int TMR_CTRL_PEND   = 2;   // write 1 to clear

    localparam reg_off_t GPIO_OUT      = 8'h00;
    localparam reg_off_t GPIO_OE       = 8'h04;
    localparam reg_off_t GPIO_IN       = 8'h08;
    localparam reg_off_t GPIO_IRQ_EN   = 8'h0C;
    localparam reg_off_t GPIO_IRQ_PEND = 8'h10;

    localparam reg_off_t RVIC_ENABLE = 8'h00;
    localparam reg_off_t RVIC_STATUS = 8'h04;
    localparam reg_off_t RVIC_ID     = 8'h08;

    // expand byte enables to a bit mask
    function automatic word_t be_mask(be_t be);
        word_t mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    function automatic word_t be_merge(word_t old_val, word_t new_val, be_t be);
        word_t mask;
        mask = be_mask(be);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

endpackage

//--- design/rst_sync.sv
// reset synchronizer, asynchronous assert and synchronous release
`timescale 1ns/1ns

module rst_sync #(
    parameter int RST_STAGES = 3
) (
    input  logic clk_i,
    input  logic arst_n_i,
    output logic rst_n_o
);

    logic [RST_STAGES-1:0] sync_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= (sync_q << 1) | RST_STAGES'(1);   // shift ones in
        end
    end

    assign rst_n_o = sync_q[RST_STAGES-1];

endmodule

//--- design/obi_decoder.sv
// address decoder routing one OBI master to N slaves, with error responder
`timescale 1ns/1ns

module obi_decoder (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::obi_req_t mst_req_i,
    output soc_pkg::obi_rsp_t mst_rsp_o,
    output soc_pkg::obi_req_t slv_req_o [soc_pkg::N_SLAVES],
    input  soc_pkg::obi_rsp_t slv_rsp_i [soc_pkg::N_SLAVES]
);
    import soc_pkg::*;

    logic [N_SLAVES-1:0] match;
    logic                hit;
    slv_idx_t            sel;
    logic                gnt;
    logic                accept;
    slv_idx_t            sel_q;       // target of the access in flight
    logic                err_pend_q;  // unmapped access awaiting its response

    always_comb begin
        match = '0;
        hit   = 1'b0;
        sel   = '0;
        for (int i = 0; i < N_SLAVES; i++) begin
            match[i] = (mst_req_i.addr & SLAVE_MASK[i]) == SLAVE_BASE[i];
            if (match[i] && !hit) begin
                hit = 1'b1;
                sel = slv_idx_t'(i);
            end
        end
    end

    // only the matched slave sees req
    always_comb begin
        for (int i = 0; i < N_SLAVES; i++) begin
            slv_req_o[i]     = mst_req_i;
            slv_req_o[i].req = mst_req_i.req & hit & (sel == slv_idx_t'(i));
        end
    end

    // unmapped requests are granted here
    assign gnt    = hit ? slv_rsp_i[sel].gnt : mst_req_i.req;
    assign accept = mst_req_i.req & gnt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q      <= '0;
            err_pend_q <= 1'b0;
        end else begin
            err_pend_q <= accept & ~hit;
            if (accept && hit) begin
                sel_q <= sel;
            end
        end
    end

    always_comb begin
        mst_rsp_o.gnt = gnt;
        if (err_pend_q) begin
            mst_rsp_o.rvalid = 1'b1;
            mst_rsp_o.err    = 1'b1;
            mst_rsp_o.rdata  = '0;
        end else begin
            mst_rsp_o.rvalid = slv_rsp_i[sel_q].rvalid;
            mst_rsp_o.err    = slv_rsp_i[sel_q].err;
            mst_rsp_o.rdata  = slv_rsp_i[sel_q].rdata;
        end
    end

endmodule

//--- design/timer_unit.sv
// up-counting timer with compare match and pending interrupt
`timescale 1ns/1ns

module timer_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::obi_req_t bus_req_i,
    output soc_pkg::obi_rsp_t bus_rsp_o,
    output logic              irq_o
);
    import soc_pkg::*;

    logic [2:0] ctrl_q;   // pend, irq_en, en
    word_t      value_q;
    word_t      count_q;

    reg_off_t off;
    logic     wr;
    logic     match;
    logic     pend_clr;
    word_t    wr_mask;
    word_t    ctrl_word;
    word_t    ctrl_merged;
    word_t    rdata_d;
    word_t    rdata_q;
    logic     rvalid_q;

    assign off         = reg_off_t'(bus_req_i.addr[7:0]);
    assign wr          = bus_req_i.req & bus_req_i.we;
    assign wr_mask     = be_mask(bus_req_i.be);
    assign ctrl_word   = word_t'(ctrl_q);
    assign ctrl_merged = be_merge(ctrl_word, bus_req_i.wdata, bus_req_i.be);
    assign match       = ctrl_q[TMR_CTRL_EN] & (count_q == value_q);
    assign pend_clr    = wr && (off == TMR_CTRL) &&
                         bus_req_i.wdata[TMR_CTRL_PEND] && wr_mask[TMR_CTRL_PEND];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= '0;
            value_q <= '0;
            count_q <= '0;
        end else begin
            if (wr && off == TMR_CTRL) begin
                ctrl_q[TMR_CTRL_EN]     <= ctrl_merged[TMR_CTRL_EN];
                ctrl_q[TMR_CTRL_IRQ_EN] <= ctrl_merged[TMR_CTRL_IRQ_EN];
            end
            if (wr && off == TMR_VALUE) begin
                value_q <= be_merge(value_q, bus_req_i.wdata, bus_req_i.be);
            end
            // a new match wins over a clear in the same cycle
            ctrl_q[TMR_CTRL_PEND] <= match | (ctrl_q[TMR_CTRL_PEND] & ~pend_clr);
            if (ctrl_q[TMR_CTRL_EN]) begin
                count_q <= match ? '0 : count_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (off)
            TMR_CTRL:  rdata_d = ctrl_word;
            TMR_VALUE: rdata_d = value_q;
            TMR_COUNT: rdata_d = count_q;
            default:   rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_req_i.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i.req) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus_rsp_o.gnt    = bus_req_i.req;   // always ready
    assign bus_rsp_o.rvalid = rvalid_q;
    assign bus_rsp_o.err    = 1'b0;
    assign bus_rsp_o.rdata  = rdata_q;

    assign irq_o = ctrl_q[TMR_CTRL_PEND] & ctrl_q[TMR_CTRL_IRQ_EN];

endmodule

//--- design/gpio_unit.sv
// gpio registers, input synchronizer and rising-edge interrupt
`timescale 1ns/1ns

module gpio_unit #(
    parameter int GPIO_NUM = 16
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  soc_pkg::obi_req_t   bus_req_i,
    output soc_pkg::obi_rsp_t   bus_rsp_o,
    input  logic [GPIO_NUM-1:0] gpio_i,
    output logic [GPIO_NUM-1:0] gpio_o,
    output logic [GPIO_NUM-1:0] gpio_oe_o,
    output logic                irq_o
);
    import soc_pkg::*;

    logic [GPIO_NUM-1:0] out_q;
    logic [GPIO_NUM-1:0] oe_q;
    logic [GPIO_NUM-1:0] irq_en_q;
    logic [GPIO_NUM-1:0] pend_q;
    logic [GPIO_NUM-1:0] sync1_q;
    logic [GPIO_NUM-1:0] sync2_q;   // GPIO_IN reads this stage
    logic [GPIO_NUM-1:0] hist_q;
    logic [GPIO_NUM-1:0] rise;

    reg_off_t off;
    logic     wr;
    word_t    out_wr;
    word_t    oe_wr;
    word_t    en_wr;
    word_t    clr_word;
    word_t    rdata_d;
    word_t    rdata_q;
    logic     rvalid_q;

    assign off      = reg_off_t'(bus_req_i.addr[7:0]);
    assign wr       = bus_req_i.req & bus_req_i.we;
    assign out_wr   = be_merge(word_t'(out_q), bus_req_i.wdata, bus_req_i.be);
    assign oe_wr    = be_merge(word_t'(oe_q), bus_req_i.wdata, bus_req_i.be);
    assign en_wr    = be_merge(word_t'(irq_en_q), bus_req_i.wdata, bus_req_i.be);
    assign clr_word = (wr && off == GPIO_IRQ_PEND) ?
                      (bus_req_i.wdata & be_mask(bus_req_i.be)) : '0;
    assign rise     = sync2_q & ~hist_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            oe_q     <= '0;
            irq_en_q <= '0;
            pend_q   <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            hist_q   <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            hist_q  <= sync2_q;
            if (wr && off == GPIO_OUT)    out_q    <= out_wr[GPIO_NUM-1:0];
            if (wr && off == GPIO_OE)     oe_q     <= oe_wr[GPIO_NUM-1:0];
            if (wr && off == GPIO_IRQ_EN) irq_en_q <= en_wr[GPIO_NUM-1:0];
            pend_q <= (pend_q & ~clr_word[GPIO_NUM-1:0]) | (rise & irq_en_q);
        end
    end

    always_comb begin
        case (off)
            GPIO_OUT:      rdata_d = word_t'(out_q);
            GPIO_OE:       rdata_d = word_t'(oe_q);
            GPIO_IN:       rdata_d = word_t'(sync2_q);
            GPIO_IRQ_EN:   rdata_d = word_t'(irq_en_q);
            GPIO_IRQ_PEND: rdata_d = word_t'(pend_q);
            default:       rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_req_i.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i.req) rdata_q <= rdata_d;
    end

    assign bus_rsp_o.gnt    = bus_req_i.req;
    assign bus_rsp_o.rvalid = rvalid_q;
    assign bus_rsp_o.err    = 1'b0;
    assign bus_rsp_o.rdata  = rdata_q;

    assign gpio_o    = out_q;
    assign gpio_oe_o = oe_q;
    assign irq_o     = |pend_q;

endmodule

//--- design/rvic.sv
// interrupt controller with enable mask and lowest-id priority
`timescale 1ns/1ns

module rvic (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  soc_pkg::obi_req_t              bus_req_i,
    output soc_pkg::obi_rsp_t              bus_rsp_o,
    input  logic [soc_pkg::N_IRQ_SRC-1:0]  src_i,
    output logic                           irq_o,
    output soc_pkg::irq_id_t               irq_id_o
);
    import soc_pkg::*;

    logic [N_IRQ_SRC-1:0] enable_q;
    logic [N_IRQ_SRC-1:0] active;
    irq_id_t              id_d;
    irq_id_t              id_q;
    logic                 irq_q;

    reg_off_t off;
    logic     wr;
    word_t    enable_wr;
    word_t    rdata_d;
    word_t    rdata_q;
    logic     rvalid_q;

    assign off       = reg_off_t'(bus_req_i.addr[7:0]);
    assign wr        = bus_req_i.req & bus_req_i.we;
    assign enable_wr = be_merge(word_t'(enable_q), bus_req_i.wdata, bus_req_i.be);
    assign active    = src_i & enable_q;

    // lowest index wins, id stays 0 when idle
    always_comb begin
        id_d = '0;
        for (int i = N_IRQ_SRC - 1; i >= 0; i--) begin
            if (active[i]) begin
                id_d = irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            irq_q    <= 1'b0;
            id_q     <= '0;
        end else begin
            if (wr && off == RVIC_ENABLE) begin
                enable_q <= enable_wr[N_IRQ_SRC-1:0];
            end
            irq_q <= |active;
            id_q  <= id_d;
        end
    end

    always_comb begin
        case (off)
            RVIC_ENABLE: rdata_d = word_t'(enable_q);
            RVIC_STATUS: rdata_d = word_t'(active);
            RVIC_ID:     rdata_d = word_t'(id_q);   // registered id, as seen on irq_id_o
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_req_i.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i.req) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus_rsp_o.gnt    = bus_req_i.req;
    assign bus_rsp_o.rvalid = rvalid_q;
    assign bus_rsp_o.err    = 1'b0;
    assign bus_rsp_o.rdata  = rdata_q;

    assign irq_o    = irq_q;
    assign irq_id_o = id_q;

endmodule

//--- design/periph_soc_top.sv
// peripheral subsystem top with decoder, two timers, gpio and interrupt controller
`timescale 1ns/1ns

module periph_soc_top #(
    parameter int GPIO_NUM   = 16,
    parameter int RST_STAGES = 3
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  soc_pkg::obi_req_t   bus_req_i,
    output soc_pkg::obi_rsp_t   bus_rsp_o,
    input  logic [GPIO_NUM-1:0] gpio_i,
    output logic [GPIO_NUM-1:0] gpio_o,
    output logic [GPIO_NUM-1:0] gpio_oe_o,
    output logic                irq_o,
    output soc_pkg::irq_id_t    irq_id_o
);
    import soc_pkg::*;

    logic                 rst_n;   // synchronized reset for all blocks
    obi_req_t             slv_req [N_SLAVES];
    wire obi_rsp_t        slv_rsp [N_SLAVES];
    wire [N_IRQ_SRC-1:0]  irq_src;

    rst_sync #(
        .RST_STAGES(RST_STAGES)
    ) u_rst_sync (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .rst_n_o (rst_n)
    );

    obi_decoder u_obi_decoder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n),
        .mst_req_i(bus_req_i),
        .mst_rsp_o(bus_rsp_o),
        .slv_req_o(slv_req),
        .slv_rsp_i(slv_rsp)
    );

    timer_unit u_timer0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n),
        .bus_req_i(slv_req[SLV_TIMER0]),
        .bus_rsp_o(slv_rsp[SLV_TIMER0]),
        .irq_o    (irq_src[IRQ_TIMER0])
    );

    timer_unit u_timer1 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n),
        .bus_req_i(slv_req[SLV_TIMER1]),
        .bus_rsp_o(slv_rsp[SLV_TIMER1]),
        .irq_o    (irq_src[IRQ_TIMER1])
    );

    gpio_unit #(
        .GPIO_NUM(GPIO_NUM)
    ) u_gpio (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n),
        .bus_req_i(slv_req[SLV_GPIO]),
        .bus_rsp_o(slv_rsp[SLV_GPIO]),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o),
        .gpio_oe_o(gpio_oe_o),
        .irq_o    (irq_src[IRQ_GPIO])
    );

    rvic u_rvic (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n),
        .bus_req_i(slv_req[SLV_RVIC]),
        .bus_rsp_o(slv_rsp[SLV_RVIC]),
        .src_i    (irq_src),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

endmodule

//--- sim/periph_soc_props.sv
// bound assertions on the bus handshake, reset values and interrupt outputs
`timescale 1ns/1ns

module periph_soc_props #(
    parameter int GPIO_NUM = 16
) (
    input logic                clk_i,
    input logic                rst_n_i,
    input soc_pkg::obi_req_t   bus_req_i,
    input soc_pkg::obi_rsp_t   bus_rsp_i,
    input logic [GPIO_NUM-1:0] gpio_oe_i,
    input logic                irq_i,
    input soc_pkg::irq_id_t    irq_id_i
);

    int   fail_cnt = 0;   // failed assertion count
    logic accepted;

    assign accepted = bus_req_i.req & bus_rsp_i.gnt;

    rvalid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accepted |=> bus_rsp_i.rvalid)
    else begin
        $error("no rvalid one cycle after an accepted request");
        fail_cnt++;
    end

    rvalid_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_rsp_i.rvalid |-> $past(accepted))
    else begin
        $error("rvalid without an accepted request the cycle before");
        fail_cnt++;
    end

    // outputs held quiet in reset
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (gpio_oe_i == '0 && !irq_i && !bus_rsp_i.rvalid))
    else begin
        $error("gpio_oe, irq or rvalid active during reset");
        fail_cnt++;
    end

    id_zero_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !irq_i |-> irq_id_i == '0)
    else begin
        $error("irq_id nonzero while irq is low");
        fail_cnt++;
    end

endmodule

bind periph_soc_top periph_soc_props #(
    .GPIO_NUM(GPIO_NUM)
) u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n),
    .bus_req_i(bus_req_i),
    .bus_rsp_i(bus_rsp_o),
    .gpio_oe_i(gpio_oe_o),
    .irq_i    (irq_o),
    .irq_id_i (irq_id_o)
);

//--- sim/tb_periph_soc.sv
// testbench for the peripheral subsystem: clock, reset, bus tasks, register model, watchdog
`timescale 1ns/1ns

module tb_periph_soc;
    import soc_pkg::*;

    localparam int GPIO_NUM   = 16;
    localparam int RST_STAGES = 3;
    localparam int N_RAND     = 12;   // random write/readback rounds
    localparam int POLL_MAX   = 100;
    // about 4 cycles per access plus the interrupt polls, doubled
    localparam int TIMEOUT_CYCLES = 2 * ((2 * N_RAND + 60) * 4 + 6 * POLL_MAX);
    localparam word_t GPIO_MASK   = (word_t'(1) << GPIO_NUM) - 1;

    logic                clk;
    logic                arst_n;
    obi_req_t            bus_req;
    obi_rsp_t            bus_rsp;
    logic [GPIO_NUM-1:0] gpio_in;
    logic [GPIO_NUM-1:0] gpio_out;
    logic [GPIO_NUM-1:0] gpio_oe;
    logic                irq;
    irq_id_t             irq_id;

    integer seed   = 32'h6b10;
    int     errors = 0;
    word_t  model_tmr_value;
    word_t  model_gpio_out;
    word_t  model_gpio_oe;

    periph_soc_top #(
        .GPIO_NUM  (GPIO_NUM),
        .RST_STAGES(RST_STAGES)
    ) periph_soc_top_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .bus_req_i(bus_req),
        .bus_rsp_o(bus_rsp),
        .gpio_i   (gpio_in),
        .gpio_o   (gpio_out),
        .gpio_oe_o(gpio_oe),
        .irq_o    (irq),
        .irq_id_o (irq_id)
    );

    always #2 clk = ~clk;

    function automatic addr_t reg_addr(int slv, reg_off_t off);
        return SLAVE_BASE[slv] + addr_t'(off);
    endfunction

    // model of a byte-enabled register write
    function automatic word_t merge_bytes(word_t old_val, word_t new_val, be_t be);
        word_t res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic bus_access(input addr_t addr, input logic we, input word_t wdata,
                              input be_t be, output word_t rdata, output logic err);
        bus_req.req   = 1'b1;
        bus_req.we    = we;
        bus_req.be    = be;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        @(negedge clk);
        while (!bus_rsp.gnt) @(negedge clk);
        @(posedge clk);   // accepted here
        #1 bus_req.req = 1'b0;
        @(negedge clk);
        while (!bus_rsp.rvalid) @(negedge clk);
        rdata = bus_rsp.rdata;
        err   = bus_rsp.err;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input addr_t addr, input word_t wdata, input be_t be);
        word_t rdata;
        logic  err;
        bus_access(addr, 1'b1, wdata, be, rdata, err);
        check_value("write err", word_t'(err), '0);
    endtask

    task automatic bus_read(input addr_t addr, output word_t rdata, output logic err);
        bus_access(addr, 1'b0, '0, 4'hF, rdata, err);
    endtask

    task automatic read_expect(input addr_t addr, input word_t exp, input logic exp_err,
                               input string what);
        word_t rdata;
        logic  err;
        bus_read(addr, rdata, err);
        assert (rdata === exp && err === exp_err) else begin
            $display("FAILED at %0t: %s at %h read %h err %b, expected %h err %b",
                     $time, what, addr, rdata, err, exp, exp_err);
            errors++;
        end
    endtask

    // bounded poll on the interrupt outputs
    task automatic wait_irq(input logic exp_irq, input irq_id_t exp_id, input string what);
        int n;
        n = 0;
        while ((irq !== exp_irq || irq_id !== exp_id) && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        check_value(what, word_t'({irq, irq_id}), word_t'({exp_irq, exp_id}));
        @(posedge clk);
        #1;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        word_t rdata;
        logic  err;
        int    sel;
        int    n;
        int    prop_errors;
        addr_t addr;
        word_t data;
        word_t exp;
        be_t   be;

        clk             = 1'b0;
        arst_n          = 1'b0;
        bus_req         = '0;
        gpio_in         = '0;
        model_tmr_value = '0;
        model_gpio_out  = '0;
        model_gpio_oe   = '0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (RST_STAGES + 1) @(posedge clk);   // internal reset release
        #1;

        for (int s = 0; s < N_SLAVES; s++) begin
            for (int o = 0; o <= ((s == SLV_GPIO) ? 16 : 8); o += 4) begin
                read_expect(reg_addr(s, reg_off_t'(o)), '0, 1'b0, "reset value");
            end
        end
        check_value("irq after reset", word_t'(irq), '0);
        check_value("gpio_oe after reset", word_t'(gpio_oe), '0);

        repeat (N_RAND) begin
            sel  = $unsigned($random(seed)) % 3;
            data = $random(seed);
            be   = $random(seed);
            case (sel)
                0: begin
                    addr            = reg_addr(SLV_TIMER0, TMR_VALUE);
                    model_tmr_value = merge_bytes(model_tmr_value, data, be);
                    exp             = model_tmr_value;
                end
                1: begin
                    addr           = reg_addr(SLV_GPIO, GPIO_OUT);
                    model_gpio_out = merge_bytes(model_gpio_out, data, be) & GPIO_MASK;
                    exp            = model_gpio_out;
                end
                default: begin
                    addr          = reg_addr(SLV_GPIO, GPIO_OE);
                    model_gpio_oe = merge_bytes(model_gpio_oe, data, be) & GPIO_MASK;
                    exp           = model_gpio_oe;
                end
            endcase
            bus_write(addr, data, be);
            read_expect(addr, exp, 1'b0, "random readback");
        end
        check_value("gpio_o pins", word_t'(gpio_out), model_gpio_out);
        check_value("gpio_oe_o pins", word_t'(gpio_oe), model_gpio_oe);

        // timer 0 match through the interrupt controller
        bus_write(reg_addr(SLV_TIMER0, TMR_VALUE), 32'd20, 4'hF);
        bus_write(reg_addr(SLV_RVIC, RVIC_ENABLE), 32'h1, 4'hF);
        bus_write(reg_addr(SLV_TIMER0, TMR_CTRL), 32'h3, 4'hF);
        wait_irq(1'b1, 8'd0, "timer 0 irq and id");
        read_expect(reg_addr(SLV_RVIC, RVIC_ID), 32'd0, 1'b0, "rvic id for timer 0");
        bus_write(reg_addr(SLV_TIMER0, TMR_CTRL), 32'h7, 4'hF);   // still running, clear
        wait_irq(1'b0, 8'd0, "timer 0 irq after clear");
        bus_write(reg_addr(SLV_TIMER0, TMR_CTRL), 32'h4, 4'hF);
        read_expect(reg_addr(SLV_TIMER0, TMR_CTRL), 32'h0, 1'b0, "timer 0 stopped");

        // rising edge on pin 3
        bus_write(reg_addr(SLV_GPIO, GPIO_IRQ_EN), 32'h8, 4'hF);
        gpio_in[3] = 1'b1;
        n = 0;
        do begin
            bus_read(reg_addr(SLV_GPIO, GPIO_IN), rdata, err);
            n++;
        end while (!rdata[3] && n < POLL_MAX);
        check_value("gpio_in level", rdata, 32'h8);
        read_expect(reg_addr(SLV_GPIO, GPIO_IRQ_PEND), 32'h8, 1'b0, "gpio pending bit 3");
        bus_write(reg_addr(SLV_RVIC, RVIC_ENABLE), 32'h4, 4'hF);
        wait_irq(1'b1, 8'd2, "gpio irq id");

        // timer 1 and gpio both pending
        bus_write(reg_addr(SLV_TIMER1, TMR_VALUE), 32'd5, 4'hF);
        bus_write(reg_addr(SLV_TIMER1, TMR_CTRL), 32'h3, 4'hF);
        bus_write(reg_addr(SLV_RVIC, RVIC_ENABLE), 32'h6, 4'hF);
        wait_irq(1'b1, 8'd1, "timer 1 over gpio");
        read_expect(reg_addr(SLV_RVIC, RVIC_ID), 32'd1, 1'b0, "rvic id for timer 1");
        read_expect(reg_addr(SLV_RVIC, RVIC_STATUS), 32'h6, 1'b0, "rvic status");
        bus_write(reg_addr(SLV_RVIC, RVIC_ENABLE), 32'h4, 4'hF);
        wait_irq(1'b1, 8'd2, "gpio with timer 1 masked");

        // unmapped space
        read_expect(32'h4000_0000, '0, 1'b1, "unmapped read");
        bus_access(32'h4000_0000, 1'b1, 32'hFFFF_FFFF, 4'hF, rdata, err);
        check_value("unmapped write err", word_t'(err), 32'h1);
        read_expect(reg_addr(SLV_TIMER1, TMR_VALUE), 32'd5, 1'b0, "mapped read after error");

        prop_errors = periph_soc_top_i.u_props.fail_cnt;
        $display("errors: %0d testbench checks, %0d bound assertions", errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
design/soc_pkg.sv
design/rst_sync.sv
design/obi_decoder.sv
design/timer_unit.sv
design/gpio_unit.sv
design/rvic.sv
design/periph_soc_top.sv
sim/periph_soc_props.sv
sim/tb_periph_soc.sv

//--- Bender.yml
package:
  name: periph_soc

sources:
  - files:
      - design/soc_pkg.sv
      - design/rst_sync.sv
      - design/obi_decoder.sv
      - design/timer_unit.sv
      - design/gpio_unit.sv
      - design/rvic.sv
      - design/periph_soc_top.sv
  - target: simulation
    files:
      - sim/periph_soc_props.sv
      - sim/tb_periph_soc.sv
